//--- lsu_golden.txt
# op type addr data expected (hex; S data is the raw store value, L data is rd)
# DW addr is the register and data the value, DR addr is the register
S SW 00000100 8badf00d 8badf00d
S SW 00000104 11223344 11223344
S SB 00000105 123456f7 f7f7f7f7
S SH 00000106 0000c3d2 c3d2c3d2
# every byte offset from 8badf00d
L LB 00000100 00000001 0000000d
L LB 00000101 00000002 fffffff0
L LB 00000102 00000003 ffffffad
L LB 00000103 00000004 ffffff8b
L LBU 00000101 00000005 000000f0
L LBU 00000103 00000006 0000008b
L LBU 00000102 00000007 000000ad
L LH 00000100 00000008 fffff00d
L LH 00000102 00000009 ffff8bad
L LHU 00000100 0000000a 0000f00d
L LHU 00000102 0000000b 00008bad
L LW 00000100 0000000c 8badf00d
# merged word c3d2f744
L LB 00000104 0000000d 00000044
L LB 00000105 0000000e fffffff7
L LBU 00000106 0000000f 000000d2
L LH 00000104 00000010 fffff744
L LHU 00000106 00000011 0000c3d2
L LW 00000104 00000012 c3d2f744
L LBU 00000100 00000013 0000000d
# debug access and x0
DW - 00000014 12345678 00000000
DR - 00000014 00000000 12345678
DW - 0000001f a5a55a5a 00000000
DR - 0000001f 00000000 a5a55a5a
DW - 00000000 ffffffff 00000000
DR - 00000000 00000000 00000000
L LW 00000100 00000000 00000000
DR - 00000000 00000000 00000000
DR - 00000001 00000000 0000000d
# store then load on consecutive cycles
S SW 00000200 cafebabe cafebabe
L LW 00000200 00000015 cafebabe
S SB 00000201 00000077 77777777
L LBU 00000201 00000016 00000077
L LW 00000200 00000017 cafe77be
S SH 00000202 ffff1234 12341234
L LH 00000202 00000018 00001234
L LW 00000200 00000019 123477be

//--- tb.f
+incdir+.
lsu_pkg.sv
lsu_request_issue.sv
lsu_wb_buffer.sv
lsu_load_writeback.sv
lsu_pipeline.sv
tb_lsu_checker.sv
tb_lsu_pipeline.sv

//--- Bender.yml
package:
  name: lsu_pipeline

sources:
  - include_dirs:
      - .
    files:
      - lsu_pkg.sv
      - lsu_request_issue.sv
      - lsu_wb_buffer.sv
      - lsu_load_writeback.sv
      - lsu_pipeline.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lsu_checker.sv
      - tb_lsu_pipeline.sv

//--- tb_lsu_pipeline.sv
`timescale 1ns/1ps

module tb_lsu_pipeline import lsu_pkg::*; ();

   localparam int    CLK_PERIOD = 10;
   localparam int    RESET_CYCLES = 8;
   localparam int    SEED = 60;
   localparam int    CYCLES_PER_LINE = 30;
   localparam string GOLDEN_FILE = "lsu_golden.txt";

   logic clk = 1'b0;
   logic reset;
   logic req_valid, req_ready, req_wen;
   mem_type_t req_type;
   xpr_t req_addr, req_wdata;
   reg_addr_t req_rd;
   logic dmem_en, dmem_wen, dmem_wait;
   mem_type_t dmem_size;
   xpr_t dmem_addr, dmem_wdata_delayed, dmem_rdata;
   logic debug_read, debug_write;
   reg_addr_t debug_addr;
   xpr_t debug_wdata, debug_rdata;
   xpr_t exp_wdata, exp_rdata;
   int test_num;

   // golden operations
   string op_q[$];
   mem_type_t type_q[$];
   xpr_t addr_q[$], data_q[$], exp_q[$];

   // memory model state
   xpr_t mem [logic [29:0]];
   logic ph_valid = 1'b0;
   xpr_t ph_addr;
   mem_type_t ph_size;
   logic ph_wen;
   int ph_seq = 0;
   int seen_seq = 0;
   int wait_left = 0;
   bit random_wait = 0;

   lsu_pipeline dut0 (.*);

   tb_lsu_checker chk0 (
      .clk(clk), .reset(reset), .dmem_en(dmem_en), .dmem_wen(dmem_wen),
      .dmem_wait(dmem_wait), .dmem_wdata_delayed(dmem_wdata_delayed),
      .debug_read(debug_read), .debug_rdata(debug_rdata),
      .exp_wdata(exp_wdata), .exp_rdata(exp_rdata), .test_num(test_num)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   function automatic xpr_t read_word(input xpr_t addr);
      if (mem.exists(addr[31:2])) begin
         return mem[addr[31:2]];
      end
      return {addr[31:2], 2'b00} ^ 32'h5a5a_a5a5;   // untouched words
   endfunction

   function automatic mem_type_t type_from_name(input string s);
      case (s)
         "LB": return MEM_TYPE_LB;
         "LH": return MEM_TYPE_LH;
         "LBU": return MEM_TYPE_LBU;
         "LHU": return MEM_TYPE_LHU;
         "SB": return MEM_TYPE_SB;
         "SH": return MEM_TYPE_SH;
         "SW": return MEM_TYPE_SW;
         default: return MEM_TYPE_LW;
      endcase
   endfunction

   task automatic merge_store(input xpr_t addr, input mem_type_t size, input xpr_t wdata);
      xpr_t mask;
      case (size)
         MEM_TYPE_SB: mask = 32'hff << {addr[1:0], 3'b000};
         MEM_TYPE_SH: mask = 32'hffff << {addr[1], 4'b0000};
         default:     mask = '1;
      endcase
      mem[addr[31:2]] = (read_word(addr) & ~mask) | (wdata & mask);
   endtask

   // address phase sampled here, data phase closes on the first edge without wait
   always @(posedge clk) begin
      if (reset) begin
         ph_valid <= 1'b0;
      end else begin
         if (ph_valid && !dmem_wait) begin
            if (ph_wen) merge_store(ph_addr, ph_size, dmem_wdata_delayed);
            ph_valid <= 1'b0;
         end
         if (dmem_en) begin
            ph_valid <= 1'b1;
            ph_addr  <= dmem_addr;
            ph_size  <= dmem_size;
            ph_wen   <= dmem_wen;
            ph_seq   <= ph_seq + 1;
         end
      end
   end

   always @(negedge clk) begin
      if (ph_valid) begin
         if (ph_seq != seen_seq) begin
            seen_seq  = ph_seq;
            wait_left = random_wait ? $urandom % 3 : 0;   // stretch of 0 to 2
         end
         dmem_wait <= (wait_left > 0);
         if (wait_left > 0) wait_left--;
         dmem_rdata <= read_word(ph_addr);
      end else begin
         dmem_wait <= 1'b0;
      end
   end

   // tasks start and end just after a falling edge
   task automatic issue_request(input logic wen, input mem_type_t t, input xpr_t addr,
                                input xpr_t wdata, input reg_addr_t rd, input xpr_t exp);
      req_valid = 1'b1;
      req_wen   = wen;
      req_type  = t;
      req_addr  = addr;
      req_wdata = wdata;
      req_rd    = rd;
      exp_wdata = exp;
      @(posedge clk);
      while (!req_ready) @(posedge clk);
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   task automatic wait_data_phase_end();
      @(posedge clk);
      while (!(ph_valid && !dmem_wait)) @(posedge clk);
      @(negedge clk);
   endtask

   task automatic read_register(input reg_addr_t r, input xpr_t exp);
      debug_read = 1'b1;
      debug_addr = r;
      exp_rdata  = exp;
      @(negedge clk);
      debug_read = 1'b0;
   endtask

   task automatic write_register(input reg_addr_t r, input xpr_t value);
      debug_write = 1'b1;
      debug_addr  = r;
      debug_wdata = value;
      @(negedge clk);
      debug_write = 1'b0;
   endtask

   task automatic run_operation(input int i);
      case (op_q[i])
         "S": issue_request(1'b1, type_q[i], addr_q[i], data_q[i], '0, exp_q[i]);
         "L": begin
            issue_request(1'b0, type_q[i], addr_q[i], '0, data_q[i][4:0], '0);
            wait_data_phase_end();
            read_register(data_q[i][4:0], exp_q[i]);
         end
         "DW": begin
            write_register(addr_q[i][4:0], data_q[i]);
            $display("test %0d: debug write x%0d <= %h done", test_num, addr_q[i][4:0],
                     data_q[i]);
         end
         default: read_register(addr_q[i][4:0], exp_q[i]);
      endcase
   endtask

   initial begin
      int fd;
      int checks_expected;
      int checks_done;
      string line, op, ty;
      xpr_t a, d, e;
      void'($urandom(SEED));
      reset = 1'b1;
      req_valid = 1'b0;
      req_wen = 1'b0;
      req_type = MEM_TYPE_LW;
      req_addr = '0;
      req_wdata = '0;
      req_rd = '0;
      dmem_rdata = '0;
      dmem_wait = 1'b0;
      debug_read = 1'b0;
      debug_write = 1'b0;
      debug_addr = '0;
      debug_wdata = '0;
      exp_wdata = '0;
      exp_rdata = '0;
      test_num = 0;
      checks_expected = 0;
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0) begin
         $display("could not open the golden file %s", GOLDEN_FILE);
         $display("Simulation failed");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            if ($fgets(line, fd) && line.len() > 1 && line[0] != "#") begin
               if ($sscanf(line, "%s %s %h %h %h", op, ty, a, d, e) == 5) begin
                  op_q.push_back(op);
                  type_q.push_back(type_from_name(ty));
                  addr_q.push_back(a);
                  data_q.push_back(d);
                  exp_q.push_back(e);
                  if (op != "DW") checks_expected += 2;   // once per pass
               end
            end
         end
         $fclose(fd);
         fork
            begin
               #(2 * op_q.size() * CYCLES_PER_LINE * CLK_PERIOD);
               $display("timeout: the run did not finish in time, a request or access hung");
               $display("Simulation failed");
               $finish;
            end
         join_none
         repeat (RESET_CYCLES) @(posedge clk);
         @(negedge clk);
         reset = 1'b0;
         // first pass without memory wait, second with random stretches
         for (int pass = 0; pass < 2; pass++) begin
            random_wait = (pass == 1);
            for (int i = 0; i < op_q.size(); i++) begin
               test_num++;
               run_operation(i);
            end
         end
         repeat (3) @(negedge clk);
         checks_done = chk0.pass_count + chk0.error_count;
         $display("checks: %0d passed, %0d failed, %0d expected", chk0.pass_count,
                  chk0.error_count, checks_expected);
         if (chk0.error_count == 0 && checks_done == checks_expected) begin
            $display("Simulation passed");
         end else begin
            if (checks_done != checks_expected)
               $display("the number of checks done does not match the golden file");
            $display("Simulation failed");
         end
         $finish;
      end
   end

endmodule

//--- tb_lsu_checker.sv
`timescale 1ns/1ps

module tb_lsu_checker import lsu_pkg::*; (
   input logic clk,
   input logic reset,
   input logic dmem_en,
   input logic dmem_wen,
   input logic dmem_wait,
   input xpr_t dmem_wdata_delayed,
   input logic debug_read,
   input xpr_t debug_rdata,
   input xpr_t exp_wdata,
   input xpr_t exp_rdata,
   input int   test_num
);

   int   pass_count = 0;
   int   error_count = 0;
   logic store_pending;
   logic read_pending;
   xpr_t store_exp;
   xpr_t read_exp;
   int   store_test;
   int   read_test;

   task automatic compare_value(input string name, input xpr_t exp, input xpr_t act,
                                input int tnum);
      if (exp === act) begin
         pass_count++;
         $display("test %0d: %s ok (%h)", tnum, name, act);
      end else begin
         error_count++;
         $display("** Error at %0t ns: test %0d %s expected %h, got %h",
                  $time, tnum, name, exp, act);
      end
   endtask

   // values from the previous edge are compared before the new ones land
   always @(posedge clk) begin
      if (reset) begin
         store_pending <= 1'b0;
         read_pending  <= 1'b0;
      end else begin
         if (store_pending) begin
            compare_value("dmem_wdata_delayed", store_exp, dmem_wdata_delayed, store_test);
         end
         if (read_pending) begin
            compare_value("debug_rdata", read_exp, debug_rdata, read_test);
         end
         store_pending <= dmem_en && dmem_wen;   // wdata shows up next cycle
         store_exp     <= exp_wdata;
         store_test    <= test_num;
         read_pending  <= debug_read;
         read_exp      <= exp_rdata;
         read_test     <= test_num;
         if (dmem_en && dmem_wait) begin
            error_count++;
            $display("** Error at %0t ns: dmem_en expected 0, got 1 while dmem_wait high",
                     $time);
         end
      end
   end

endmodule

//--- lsu_pipeline.sv
`timescale 1ns/1ps

module lsu_pipeline import lsu_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      req_valid,
   output logic      req_ready,
   input  logic      req_wen,
   input  mem_type_t req_type,
   input  xpr_t      req_addr,
   input  xpr_t      req_wdata,
   input  reg_addr_t req_rd,
   output logic      dmem_en,
   output logic      dmem_wen,
   output mem_type_t dmem_size,
   output xpr_t      dmem_addr,
   output xpr_t      dmem_wdata_delayed,
   input  xpr_t      dmem_rdata,
   input  logic      dmem_wait,
   input  logic      debug_read,
   input  logic      debug_write,
   input  reg_addr_t debug_addr,
   input  xpr_t      debug_wdata,
   output xpr_t      debug_rdata
);

   // issue to data-phase register
   logic       acc_valid;
   logic       acc_wen;
   mem_type_t  acc_type;
   logic [1:0] acc_addr_lo;
   xpr_t       acc_wdata;
   reg_addr_t  acc_rd;

   // data-phase register to writeback
   logic       wb_valid;
   logic       wb_wen;
   mem_type_t  wb_type;
   logic [1:0] wb_addr_lo;
   reg_addr_t  wb_rd;

   lsu_request_issue u_issue (
      .clk         (clk),
      .reset       (reset),
      .req_valid   (req_valid),
      .req_wen     (req_wen),
      .req_type    (req_type),
      .req_addr    (req_addr),
      .req_wdata   (req_wdata),
      .req_rd      (req_rd),
      .dmem_wait   (dmem_wait),
      .debug_write (debug_write),
      .req_ready   (req_ready),
      .dmem_en     (dmem_en),
      .dmem_wen    (dmem_wen),
      .dmem_size   (dmem_size),
      .dmem_addr   (dmem_addr),
      .acc_valid   (acc_valid),
      .acc_wen     (acc_wen),
      .acc_type    (acc_type),
      .acc_addr_lo (acc_addr_lo),
      .acc_wdata   (acc_wdata),
      .acc_rd      (acc_rd)
   );

   lsu_wb_buffer u_buffer (
      .clk                (clk),
      .reset              (reset),
      .dmem_wait          (dmem_wait),
      .acc_valid          (acc_valid),
      .acc_wen            (acc_wen),
      .acc_type           (acc_type),
      .acc_addr_lo        (acc_addr_lo),
      .acc_wdata          (acc_wdata),
      .acc_rd             (acc_rd),
      .wb_valid           (wb_valid),
      .wb_wen             (wb_wen),
      .wb_type            (wb_type),
      .wb_addr_lo         (wb_addr_lo),
      .wb_rd              (wb_rd),
      .dmem_wdata_delayed (dmem_wdata_delayed)
   );

   lsu_load_writeback u_writeback (
      .clk         (clk),
      .reset       (reset),
      .wb_valid    (wb_valid),
      .wb_wen      (wb_wen),
      .wb_type     (wb_type),
      .wb_addr_lo  (wb_addr_lo),
      .wb_rd       (wb_rd),
      .dmem_rdata  (dmem_rdata),
      .dmem_wait   (dmem_wait),
      .debug_read  (debug_read),
      .debug_write (debug_write),
      .debug_addr  (debug_addr),
      .debug_wdata (debug_wdata),
      .debug_rdata (debug_rdata)
   );

endmodule

//--- lsu_load_writeback.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_load_writeback import lsu_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       wb_valid,
   input  logic       wb_wen,
   input  mem_type_t  wb_type,
   input  logic [1:0] wb_addr_lo,
   input  reg_addr_t  wb_rd,
   input  xpr_t       dmem_rdata,
   input  logic       dmem_wait,
   input  logic       debug_read,
   input  logic       debug_write,
   input  reg_addr_t  debug_addr,
   input  xpr_t       debug_wdata,
   output xpr_t       debug_rdata
);

   xpr_t      regs [`N_REGS];
   xpr_t      shifted_data;
   xpr_t      load_data;
   logic      load_done;
   logic      rf_wen;
   reg_addr_t rf_waddr;
   xpr_t      rf_wdata;

   // addressed byte moves down to lane 0
   assign shifted_data = dmem_rdata >> {wb_addr_lo, 3'b000};

   always_comb begin
      case (wb_type)
         MEM_TYPE_LB:
            load_data = {{(`XPR_LEN-8){shifted_data[7]}}, shifted_data[7:0]};
         MEM_TYPE_LH:
            load_data = {{(`XPR_LEN-16){shifted_data[15]}}, shifted_data[15:0]};
         MEM_TYPE_LBU:
            load_data = {{(`XPR_LEN-8){1'b0}}, shifted_data[7:0]};
         MEM_TYPE_LHU:
            load_data = {{(`XPR_LEN-16){1'b0}}, shifted_data[15:0]};
         default:
            load_data = shifted_data;   // LW
      endcase
   end

   // load completes on the last data-phase cycle
   assign load_done = wb_valid & ~wb_wen & ~dmem_wait;

   // debug write wins over the load writeback
   assign rf_wen   = debug_write | load_done;
   assign rf_waddr = debug_write ? debug_addr : wb_rd;
   assign rf_wdata = debug_write ? debug_wdata : load_data;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `N_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (rf_wen && rf_waddr != '0) begin
         regs[rf_waddr] <= rf_wdata;   // x0 stays zero
      end
   end

   // registered debug read
   always_ff @(posedge clk) begin
      if (debug_read) begin
         debug_rdata <= regs[debug_addr];
      end
   end

   // a colliding debug write would silently drop the load result
   no_debug_load_clash: assert property (
      @(posedge clk) disable iff (reset)
      !(debug_write && load_done)
   ) else $error("debug write collided with load writeback");

endmodule

//--- lsu_wb_buffer.sv
`timescale 1ns/1ps

module lsu_wb_buffer import lsu_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       dmem_wait,
   input  logic       acc_valid,
   input  logic       acc_wen,
   input  mem_type_t  acc_type,
   input  logic [1:0] acc_addr_lo,
   input  xpr_t       acc_wdata,
   input  reg_addr_t  acc_rd,
   output logic       wb_valid,
   output logic       wb_wen,
   output mem_type_t  wb_type,
   output logic [1:0] wb_addr_lo,
   output reg_addr_t  wb_rd,
   output xpr_t       dmem_wdata_delayed
);

   // data phase ends on the first edge with dmem_wait low
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_valid <= 1'b0;
      end else if (!dmem_wait) begin
         wb_valid <= acc_valid;   // drops out when nothing new came in
      end
   end

   always_ff @(posedge clk) begin
      if (!dmem_wait && acc_valid) begin
         wb_wen             <= acc_wen;
         wb_type            <= acc_type;
         wb_addr_lo         <= acc_addr_lo;
         wb_rd              <= acc_rd;
         dmem_wdata_delayed <= acc_wdata;   // already lane-replicated
      end
   end

   // a new access landing during a stall would overwrite the held one
   acc_no_issue_during_wait: assert property (
      @(posedge clk) disable iff (reset)
      acc_valid |-> !dmem_wait
   ) else $error("access issued while data phase stalled");

endmodule

//--- lsu_request_issue.sv
`timescale 1ns/1ps

module lsu_request_issue import lsu_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       req_valid,
   input  logic       req_wen,
   input  mem_type_t  req_type,
   input  xpr_t       req_addr,
   input  xpr_t       req_wdata,
   input  reg_addr_t  req_rd,
   input  logic       dmem_wait,
   input  logic       debug_write,
   output logic       req_ready,
   output logic       dmem_en,
   output logic       dmem_wen,
   output mem_type_t  dmem_size,
   output xpr_t       dmem_addr,
   output logic       acc_valid,
   output logic       acc_wen,
   output mem_type_t  acc_type,
   output logic [1:0] acc_addr_lo,
   output xpr_t       acc_wdata,
   output reg_addr_t  acc_rd
);

   logic fire;

   // no new address phase while memory stalls or debug owns the write port
   assign req_ready = ~dmem_wait & ~debug_write;
   assign fire      = req_valid & req_ready;

   // address phase in the cycle of acceptance
   assign dmem_en   = fire;
   assign dmem_wen  = req_wen;
   assign dmem_size = req_type;
   assign dmem_addr = req_addr;

   // handed on to the data-phase register
   assign acc_valid   = fire;
   assign acc_wen     = req_wen;
   assign acc_type    = req_type;
   assign acc_addr_lo = req_addr[1:0];
   assign acc_rd      = req_rd;

   // byte and halfword stores go out on every lane
   always_comb begin
      case (req_type)
         MEM_TYPE_SB: acc_wdata = {4{req_wdata[7:0]}};
         MEM_TYPE_SH: acc_wdata = {2{req_wdata[15:0]}};
         default:     acc_wdata = req_wdata;
      endcase
   end

   // a stalled request must not change under the handshake
   req_hold_stable: assert property (
      @(posedge clk) disable iff (reset)
      req_valid && !req_ready |=>
         $stable({req_wen, req_type, req_addr, req_wdata, req_rd})
   ) else $error("request fields changed while stalled");

endmodule

//--- lsu_pkg.sv
`include "lsu_settings.svh"

package lsu_pkg;

   // one data or address word
   typedef logic [`XPR_LEN-1:0] xpr_t;

   // register index
   typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

   // load types keep the RISC-V funct3 codes and stores fill the gaps
   typedef enum logic [`MEM_TYPE_WIDTH-1:0] {
      MEM_TYPE_LB  = 3'd0,
      MEM_TYPE_LH  = 3'd1,
      MEM_TYPE_LW  = 3'd2,
      MEM_TYPE_SB  = 3'd3,
      MEM_TYPE_LBU = 3'd4,
      MEM_TYPE_LHU = 3'd5,
      MEM_TYPE_SH  = 3'd6,
      MEM_TYPE_SW  = 3'd7
   } mem_type_t;

endpackage

//--- lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data and address width
`define XPR_LEN 32

// register file geometry
`define REG_ADDR_WIDTH 5
`define N_REGS 32

// memory-type code for all loads and stores
`define MEM_TYPE_WIDTH 3

`endif
